// ==== filelist.f ====
+incdir+testbench
logic/fft_pkg.sv
logic/fft_frame_loader.sv
logic/fft_butterfly.sv
logic/fft_stage.sv
logic/fft_frame_unloader.sv
logic/fft_top.sv
testbench/fft_top_checker.sv
testbench/tb_fft.sv

// ==== logic/fft_butterfly.sv ====
`default_nettype none
`timescale 1ns/1ns

module fft_butterfly #(
  parameter int TW_IDX = 0
) (
  input  logic           clk,
  input  logic           arst_n,

  input  fft_pkg::cplx_t a,
  input  fft_pkg::cplx_t b,
  input  logic           recv_val,
  output logic           recv_rdy,

  output fft_pkg::cplx_t c,
  output fft_pkg::cplx_t d,
  output logic           send_val,
  input  logic           send_rdy
);

  localparam int DATA_W = fft_pkg::DATA_W;
  localparam int PROD_W = 2 * DATA_W;
  localparam int SUM_W  = DATA_W + 1;

  // W^k = cos - j*sin.
  localparam logic signed [DATA_W-1:0] W_COS =
    fft_pkg::SINE_LUT[(TW_IDX + fft_pkg::N_POINTS / 4) % fft_pkg::N_POINTS];
  localparam logic signed [DATA_W-1:0] W_SIN = fft_pkg::SINE_LUT[TW_IDX];

  logic signed [PROD_W-1:0] p_re_cos;
  logic signed [PROD_W-1:0] p_im_sin;
  logic signed [PROD_W-1:0] p_im_cos;
  logic signed [PROD_W-1:0] p_re_sin;
  logic signed [PROD_W-1:0] t_re_full;
  logic signed [PROD_W-1:0] t_im_full;
  logic signed [DATA_W-1:0] t_re;
  logic signed [DATA_W-1:0] t_im;
  logic        [SUM_W-1:0]  sum_c_re;
  logic        [SUM_W-1:0]  sum_c_im;
  logic        [SUM_W-1:0]  sum_d_re;
  logic        [SUM_W-1:0]  sum_d_im;
  logic                     full;

  // ==========================================================
  // Twiddle multiply, t = b * W
  // ==========================================================

  assign p_re_cos = PROD_W'(b.re) * PROD_W'(W_COS);
  assign p_im_sin = PROD_W'(b.im) * PROD_W'(W_SIN);
  assign p_im_cos = PROD_W'(b.im) * PROD_W'(W_COS);
  assign p_re_sin = PROD_W'(b.re) * PROD_W'(W_SIN);

  assign t_re_full = (p_re_cos >>> fft_pkg::FRAC_W) + (p_im_sin >>> fft_pkg::FRAC_W);
  assign t_im_full = (p_im_cos >>> fft_pkg::FRAC_W) - (p_re_sin >>> fft_pkg::FRAC_W);
  assign t_re      = t_re_full[DATA_W-1:0];
  assign t_im      = t_im_full[DATA_W-1:0];

  // Sign-extended sums, halved on the way into the register.
  assign sum_c_re = {a.re[DATA_W-1], a.re} + {t_re[DATA_W-1], t_re};
  assign sum_c_im = {a.im[DATA_W-1], a.im} + {t_im[DATA_W-1], t_im};
  assign sum_d_re = {a.re[DATA_W-1], a.re} - {t_re[DATA_W-1], t_re};
  assign sum_d_im = {a.im[DATA_W-1], a.im} - {t_im[DATA_W-1], t_im};

  // ==========================================================
  // One-deep output buffer
  // ==========================================================

  assign recv_rdy = !full || send_rdy;        // Refill on the same edge as release.
  assign send_val = full;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      full <= 1'b0;
    end else if (recv_val && recv_rdy) begin
      full <= 1'b1;
    end else if (send_rdy) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (recv_val && recv_rdy) begin
      c.re <= sum_c_re[SUM_W-1:1];
      c.im <= sum_c_im[SUM_W-1:1];
      d.re <= sum_d_re[SUM_W-1:1];
      d.im <= sum_d_im[SUM_W-1:1];
    end
  end

endmodule

`default_nettype wire

// ==== logic/fft_frame_loader.sv ====
`default_nettype none
`timescale 1ns/1ns

module fft_frame_loader (
  input  logic            clk,
  input  logic            arst_n,

  input  fft_pkg::cplx_t  in_sample,
  input  logic            in_valid,
  output logic            in_ready,

  output fft_pkg::frame_t frame,
  output logic            frame_val,
  input  logic            frame_rdy
);

  logic [fft_pkg::LOG2_N-1:0] count;
  logic [fft_pkg::LOG2_N-1:0] slot;
  logic                       accept;
  logic                       take;

  assign in_ready = !frame_val;               // Blocked while a full frame waits.
  assign accept   = in_valid && in_ready;
  assign take     = frame_val && frame_rdy;

  // Slot index is the count with its bits reversed.
  always_comb begin
    for (int i = 0; i < fft_pkg::LOG2_N; i++) begin
      slot[i] = count[fft_pkg::LOG2_N-1-i];
    end
  end

  // ==========================================================
  // Control
  // ==========================================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count     <= '0;
      frame_val <= 1'b0;
    end else begin
      if (accept) begin
        count <= count + 1'b1;                // Wraps after the last sample.
      end
      if (accept && (count == '1)) begin
        frame_val <= 1'b1;
      end else if (take) begin
        frame_val <= 1'b0;
      end
    end
  end

  // Sample storage.
  always_ff @(posedge clk) begin
    if (accept) begin
      frame[slot] <= in_sample;
    end
  end

endmodule

`default_nettype wire

// ==== logic/fft_frame_unloader.sv ====
`default_nettype none
`timescale 1ns/1ns

module fft_frame_unloader (
  input  logic                       clk,
  input  logic                       arst_n,

  input  fft_pkg::frame_t            frame,
  input  logic                       frame_val,
  output logic                       frame_rdy,

  output fft_pkg::cplx_t             out_sample,
  output logic [fft_pkg::LOG2_N-1:0] out_index,
  output logic                       out_valid,
  input  logic                       out_ready
);

  fft_pkg::frame_t            held;
  logic [fft_pkg::LOG2_N-1:0] bin;
  logic                       full;
  logic                       take;
  logic                       emit;

  assign frame_rdy  = !full;
  assign take       = frame_val && frame_rdy;
  assign emit       = out_valid && out_ready;

  assign out_valid  = full;
  assign out_sample = held[bin];              // Natural order, bin 0 first.
  assign out_index  = bin;

  // ==========================================================
  // Bin sequencing
  // ==========================================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      full <= 1'b0;
      bin  <= '0;
    end else if (take) begin
      full <= 1'b1;
      bin  <= '0;
    end else if (emit) begin
      bin <= bin + 1'b1;
      if (bin == '1) begin
        full <= 1'b0;                         // Last bin gone.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      held <= frame;
    end
  end

endmodule

`default_nettype wire

// ==== logic/fft_pkg.sv ====
`default_nettype none

package fft_pkg;

  // ==========================================================
  // Sizes
  // ==========================================================

  localparam int N_POINTS = 8;                 // FFT length.
  localparam int LOG2_N   = 3;                 // Stage count and bin index width.
  localparam int DATA_W   = 16;                // Width of one real or imaginary part.
  localparam int FRAC_W   = 14;                // Twiddle fraction bits, Q2.14.

  // ==========================================================
  // Sample and frame types
  // ==========================================================

  typedef struct packed {
    logic signed [DATA_W-1:0] re;
    logic signed [DATA_W-1:0] im;
  } cplx_t;

  // Element 0 sits in the lowest 32 bits.
  typedef cplx_t [N_POINTS-1:0] frame_t;

  // ==========================================================
  // Twiddle table
  // ==========================================================

  // sin(2*pi*k/N) in Q2.14; the cosine is read at (k + N/4) mod N.
  localparam logic signed [DATA_W-1:0] SINE_LUT [N_POINTS] = '{
    16'sd0,
    16'sd11585,
    16'sd16384,
    16'sd11585,
    16'sd0,
    -16'sd11585,
    -16'sd16384,
    -16'sd11585
  };

endpackage

`default_nettype wire

// ==== logic/fft_stage.sv ====
`default_nettype none
`timescale 1ns/1ns

module fft_stage #(
  parameter int STAGE = 0
) (
  input  logic            clk,
  input  logic            arst_n,

  input  fft_pkg::frame_t recv_frame,
  input  logic            recv_val,
  output logic            recv_rdy,

  output fft_pkg::frame_t send_frame,
  output logic            send_val,
  input  logic            send_rdy
);

  localparam int N_PTS  = fft_pkg::N_POINTS;
  localparam int N_BFLY = N_PTS / 2;
  localparam int HALF   = 1 << STAGE;         // Distance between the two inputs.

  logic [N_BFLY-1:0] bf_recv_rdy;
  logic [N_BFLY-1:0] bf_send_val;
  logic              bf_send_rdy;

  // ==========================================================
  // Frame-level handshake join
  // ==========================================================

  assign recv_rdy    = &bf_recv_rdy;          // Frame enters only if all can take it.
  assign send_val    = &bf_send_val;
  assign bf_send_rdy = send_rdy && send_val;  // All butterflies release together.

  // ==========================================================
  // Butterflies
  // ==========================================================

  // Pair selection and write-back use the same indices, so the
  // crossbar collapses into the port connections below.
  for (genvar bf = 0; bf < N_BFLY; bf++) begin : g_bfly
    localparam int UPPER  = (bf / HALF) * 2 * HALF + bf % HALF;
    localparam int LOWER  = UPPER + HALF;
    localparam int TW_SEL = (bf % HALF) * (N_PTS / (2 * HALF));

    fft_butterfly #(
      .TW_IDX(TW_SEL)
    ) u_bfly (
      .clk     (clk),
      .arst_n  (arst_n),
      .a       (recv_frame[UPPER]),
      .b       (recv_frame[LOWER]),
      .recv_val(recv_val),
      .recv_rdy(bf_recv_rdy[bf]),
      .c       (send_frame[UPPER]),
      .d       (send_frame[LOWER]),
      .send_val(bf_send_val[bf]),
      .send_rdy(bf_send_rdy)
    );
  end

endmodule

`default_nettype wire

// ==== logic/fft_top.sv ====
`default_nettype none
`timescale 1ns/1ns

module fft_top (
  input  logic                       clk,
  input  logic                       arst_n,

  input  fft_pkg::cplx_t             in_sample,
  input  logic                       in_valid,
  output logic                       in_ready,

  output fft_pkg::cplx_t             out_sample,
  output logic [fft_pkg::LOG2_N-1:0] out_index,
  output logic                       out_valid,
  input  logic                       out_ready
);

  localparam int N_STAGES = fft_pkg::LOG2_N;

  // Link s feeds stage s; the last link feeds the unloader.
  fft_pkg::frame_t     link_frame [N_STAGES+1];
  logic [N_STAGES:0]   link_val;
  logic [N_STAGES:0]   link_rdy;

  fft_frame_loader u_loader (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_sample(in_sample),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .frame    (link_frame[0]),
    .frame_val(link_val[0]),
    .frame_rdy(link_rdy[0])
  );

  for (genvar s = 0; s < N_STAGES; s++) begin : g_stage
    fft_stage #(
      .STAGE(s)
    ) u_stage (
      .clk       (clk),
      .arst_n    (arst_n),
      .recv_frame(link_frame[s]),
      .recv_val  (link_val[s]),
      .recv_rdy  (link_rdy[s]),
      .send_frame(link_frame[s+1]),
      .send_val  (link_val[s+1]),
      .send_rdy  (link_rdy[s+1])
    );
  end

  fft_frame_unloader u_unloader (
    .clk       (clk),
    .arst_n    (arst_n),
    .frame     (link_frame[N_STAGES]),
    .frame_val (link_val[N_STAGES]),
    .frame_rdy (link_rdy[N_STAGES]),
    .out_sample(out_sample),
    .out_index (out_index),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the FFT testbench with Verilator; the log decides pass or fail.
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert -Wno-fatal --top-module tb_fft -f filelist.f \
    && ./obj_dir/Vtb_fft +verilator+error+limit+1000; } > sim.log 2>&1 \
  || { cat sim.log; echo "FAIL: build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "FAIL: no result line in sim.log"; exit 1; }
echo "PASS"

// ==== testbench/fft_top_checker.sv ====
`default_nettype none
`timescale 1ns/1ns

module fft_top_checker (
  input logic                       clk,
  input logic                       arst_n,
  input logic                       in_valid,
  input fft_pkg::cplx_t             out_sample,
  input logic [fft_pkg::LOG2_N-1:0] out_index,
  input logic                       out_valid,
  input logic                       out_ready
);

  int fail_count = 0;                         // Read by the testbench at the end.

  // ==========================================================
  // Handshake rules
  // ==========================================================

  a_quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
    else begin
      $error("out_valid is high while reset is asserted");
      fail_count++;
    end

  a_hold_stalled: assert property (@(posedge clk) disable iff (!arst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_sample) && $stable(out_index)))
    else begin
      $error("output changed while stalled by out_ready");
      fail_count++;
    end

  a_in_valid_known: assert property (@(posedge clk) !$isunknown(in_valid))
    else begin
      $error("in_valid is unknown");
      fail_count++;
    end

endmodule

bind fft_top fft_top_checker u_checker (
  .clk       (clk),
  .arst_n    (arst_n),
  .in_valid  (in_valid),
  .out_sample(out_sample),
  .out_index (out_index),
  .out_valid (out_valid),
  .out_ready (out_ready)
);

`default_nettype wire

// ==== testbench/tb_fft_model.svh ====
`ifndef TB_FFT_MODEL_SVH
`define TB_FFT_MODEL_SVH

// ============================================================
// Fixed-point FFT model, bins returned in natural order
// ============================================================

function automatic int bit_reverse(input int idx);
  int rev;
  rev = 0;
  for (int b = 0; b < fft_pkg::LOG2_N; b++) begin
    if (((idx >> b) & 1) != 0) begin
      rev = rev | (1 << (fft_pkg::LOG2_N - 1 - b));
    end
  end
  return rev;
endfunction

// Floor of sum / 2, kept to the sample width.
function automatic logic signed [15:0] halve_sum(input int sum);
  int q;
  q = sum >>> 1;
  return q[15:0];
endfunction

function automatic fft_pkg::frame_t fft_model(input fft_pkg::frame_t x);
  fft_pkg::frame_t    v;
  fft_pkg::cplx_t     a;
  fft_pkg::cplx_t     b;
  logic signed [15:0] w_cos;
  logic signed [15:0] w_sin;
  int                 h;
  int                 k;
  int                 t_re;
  int                 t_im;
  for (int i = 0; i < fft_pkg::N_POINTS; i++) begin
    v[bit_reverse(i)] = x[i];
  end
  for (int s = 0; s < fft_pkg::LOG2_N; s++) begin
    h = 1 << s;
    for (int base = 0; base < fft_pkg::N_POINTS; base += 2 * h) begin
      for (int j = 0; j < h; j++) begin
        k     = j * (fft_pkg::N_POINTS / (2 * h));
        w_sin = fft_pkg::SINE_LUT[k];
        w_cos = fft_pkg::SINE_LUT[(k + fft_pkg::N_POINTS / 4) % fft_pkg::N_POINTS];
        a     = v[base + j];
        b     = v[base + j + h];
        // Multiply by cos - j*sin, each product truncated on its own.
        t_re = ((int'(b.re) * int'(w_cos)) >>> fft_pkg::FRAC_W)
             + ((int'(b.im) * int'(w_sin)) >>> fft_pkg::FRAC_W);
        t_im = ((int'(b.im) * int'(w_cos)) >>> fft_pkg::FRAC_W)
             - ((int'(b.re) * int'(w_sin)) >>> fft_pkg::FRAC_W);
        t_re = int'($signed(t_re[15:0]));           // Twiddled value is 16 bits wide.
        t_im = int'($signed(t_im[15:0]));
        v[base + j].re     = halve_sum(int'(a.re) + t_re);
        v[base + j].im     = halve_sum(int'(a.im) + t_im);
        v[base + j + h].re = halve_sum(int'(a.re) - t_re);
        v[base + j + h].im = halve_sum(int'(a.im) - t_im);
      end
    end
  end
  return v;
endfunction

`endif

// ==== testbench/tb_fft.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_fft;

  localparam int RAND_FRAMES = 40;
  localparam int ALL_BINS    = (RAND_FRAMES + 1) * fft_pkg::N_POINTS; // Impulse frame first.
  localparam int MAX_CYCLES  = RAND_FRAMES * fft_pkg::N_POINTS * 4 + 200;

  logic                       clk;
  logic                       arst_n;
  fft_pkg::cplx_t             in_sample;
  logic                       in_valid;
  logic                       in_ready;
  fft_pkg::cplx_t             out_sample;
  logic [fft_pkg::LOG2_N-1:0] out_index;
  logic                       out_valid;
  logic                       out_ready;

  integer         seed;
  int             errors;
  int             bins_seen;
  int             cycles;
  fft_pkg::cplx_t expect_q [$];

  `include "tb_fft_model.svh"

  fft_top dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_sample (in_sample),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_sample(out_sample),
    .out_index (out_index),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  always #5 clk = ~clk;

  // ==========================================================
  // Stimulus helpers
  // ==========================================================

  task automatic next_cycle();
    int rnd;
    @(posedge clk);
    #1;
    rnd       = $random(seed);
    out_ready = rnd[0];
  endtask

  function automatic logic signed [15:0] random_part();
    int v;
    v = $random(seed) % 8001;                 // Stays within +-8000.
    return v[15:0];
  endfunction

  task automatic send_frame(input fft_pkg::frame_t samples);
    fft_pkg::frame_t spectrum;
    int              i;
    int              pick;
    logic            accepted;
    spectrum = fft_model(samples);
    for (int k = 0; k < fft_pkg::N_POINTS; k++) begin
      expect_q.push_back(spectrum[k]);
    end
    i = 0;
    while (i < fft_pkg::N_POINTS) begin
      pick      = {$random(seed)} % 10;
      in_sample = samples[i];
      in_valid  = (pick < 7);
      @(negedge clk);
      accepted = in_valid && in_ready;
      next_cycle();
      if (accepted) begin
        i++;
      end
    end
    in_valid = 1'b0;
  endtask

  // ==========================================================
  // Output checking
  // ==========================================================

  task automatic check_bin();
    fft_pkg::cplx_t             exp_bin;
    logic [fft_pkg::LOG2_N-1:0] exp_idx;
    exp_idx = bins_seen[fft_pkg::LOG2_N-1:0];
    if (expect_q.size() == 0) begin
      errors++;
      $display("[ERROR] %0t: bin %0d arrived with no frame outstanding", $time, out_index);
    end else begin
      exp_bin = expect_q.pop_front();
      if (out_sample !== exp_bin) begin
        errors++;
        $display("[ERROR] %0t: bin %0d got (%0d, %0d), expected (%0d, %0d)", $time,
                 bins_seen, out_sample.re, out_sample.im, exp_bin.re, exp_bin.im);
      end
    end
    if (out_index !== exp_idx) begin
      errors++;
      $display("[ERROR] %0t: out_index %0d, expected %0d", $time, out_index, exp_idx);
    end
    if (bins_seen < fft_pkg::N_POINTS) begin // Impulse spectrum is flat.
      if (out_sample.re !== 16'sd1024) begin
        errors++;
        $display("[ERROR] %0t: impulse bin re %0d, expected 1024", $time, out_sample.re);
      end
      if (out_sample.im !== 16'sd0) begin
        errors++;
        $display("[ERROR] %0t: impulse bin im %0d, expected 0", $time, out_sample.im);
      end
    end
    bins_seen++;
  endtask

  always @(negedge clk) begin
    if (arst_n && out_valid && out_ready) begin
      check_bin();
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout: %0d of %0d bins received after %0d cycles", bins_seen, ALL_BINS,
               cycles);
      $display("Errors: %0d, bins received: %0d of %0d", errors, bins_seen, ALL_BINS);
      $display("Done: errors found");
      $finish;
    end
  end

  // ==========================================================
  // Main sequence
  // ==========================================================

  initial begin
    fft_pkg::frame_t frame_in;
    seed      = 91463;
    errors    = 0;
    bins_seen = 0;
    cycles    = 0;
    clk       = 1'b0;
    arst_n    = 1'b0;
    in_sample = '0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(negedge clk);
    if (out_valid !== 1'b0) begin
      errors++;
      $display("[ERROR] %0t: out_valid high after reset", $time);
    end
    if (in_ready !== 1'b1) begin
      errors++;
      $display("[ERROR] %0t: in_ready low after reset", $time);
    end
    next_cycle();
    frame_in       = '0;
    frame_in[0].re = 16'sd8192;
    send_frame(frame_in);
    for (int f = 0; f < RAND_FRAMES; f++) begin
      for (int i = 0; i < fft_pkg::N_POINTS; i++) begin
        frame_in[i].re = random_part();
        frame_in[i].im = random_part();
      end
      send_frame(frame_in);
    end
    while (bins_seen < ALL_BINS) begin
      next_cycle();
    end
    repeat (20) next_cycle();                 // Any extra bin would show up here.
    if (bins_seen != ALL_BINS) begin
      errors++;
      $display("[ERROR] %0t: %0d bins received, expected %0d", $time, bins_seen, ALL_BINS);
    end
    errors += dut.u_checker.fail_count;
    $display("Errors: %0d, bins received: %0d of %0d", errors, bins_seen, ALL_BINS);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
